//--- src/opn_reg_pkg.sv
package opn_reg_pkg;

	// ##############################
	// Host bus and register map
	// ##############################

	localparam int BUS_W = 8;
	localparam logic [BUS_W/2-1:0] GLOBAL_GROUP = 4'h2; // Upper nibble of 0x20-0x2F.

	localparam logic [BUS_W-1:0] REG_TIMER_A_HI = 8'h24;
	localparam logic [BUS_W-1:0] REG_TIMER_A_LO = 8'h25;
	localparam logic [BUS_W-1:0] REG_TIMER_B = 8'h26;
	localparam logic [BUS_W-1:0] REG_TIMER_CTRL = 8'h27;
	localparam logic [BUS_W-1:0] REG_KEY_ON = 8'h28;

	// ##############################
	// Timers and key-on table
	// ##############################

	localparam int TIMER_A_W = 10;
	localparam int TIMER_B_W = 8;
	localparam int TIMER_B_PRESCALE = 16; // Ticks per timer B count.

	localparam int NUM_CH = 6;
	localparam int NUM_SLOTS = 4;
	localparam int KEY_W = NUM_CH * NUM_SLOTS;

	// Codes 01 and 11 both select channel 3 special mode.
	localparam logic [1:0] MODE_NORMAL = 2'b00;
	localparam logic [1:0] MODE_CSM = 2'b10;

	typedef union packed {
		struct packed {
			logic [BUS_W/2-1:0] group;
			logic [BUS_W/2-1:0] index;
		} addr; // Address write.
		struct packed {
			logic [1:0] mode;
			logic reset_b;
			logic reset_a;
			logic en_b;
			logic en_a;
			logic load_b;
			logic load_a;
		} ctrl; // Data write to 0x27.
	} opn_bus_word_t;

endpackage

//--- src/opn_bus_latch.sv
module opn_bus_latch (
	input logic mclk_i,
	input logic rst_i,
	input logic addr_wr_i,
	input logic data_wr_i,
	input logic bank_i,
	input opn_reg_pkg::opn_bus_word_t bus_data_i,
	output logic reg_wr_o,
	output logic [3:0] reg_index_o,
	output opn_reg_pkg::opn_bus_word_t reg_data_o
);
	import opn_reg_pkg::*;

	logic addr_hit;
	logic addr_valid;
	logic [3:0] addr_index;

	// Only the timer and key-on registers 0x24..0x28 of bank 0 are claimed here.
	assign addr_hit = !bank_i
		&& (bus_data_i.addr.group == GLOBAL_GROUP)
		&& (bus_data_i.addr.index >= REG_TIMER_A_HI[3:0])
		&& (bus_data_i.addr.index <= REG_KEY_ON[3:0]);

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			addr_valid <= 1'b0;
			reg_wr_o <= 1'b0;
		end else begin
			reg_wr_o <= data_wr_i & addr_valid; // One cycle strobe.
			if (addr_wr_i) begin
				addr_valid <= addr_hit; // Stays set over repeated data writes.
			end
		end
	end

	always_ff @(posedge mclk_i) begin
		if (addr_wr_i) begin
			addr_index <= bus_data_i.addr.index;
		end
		if (data_wr_i && addr_valid) begin
			reg_index_o <= addr_index;
			reg_data_o <= bus_data_i;
		end
	end

endmodule

//--- src/opn_global_regs.sv
module opn_global_regs (
	input logic mclk_i,
	input logic rst_i,
	input logic reg_wr_i,
	input logic [3:0] reg_index_i,
	input opn_reg_pkg::opn_bus_word_t reg_data_i,
	output logic [opn_reg_pkg::TIMER_A_W-1:0] timer_a_val_o,
	output logic [opn_reg_pkg::TIMER_B_W-1:0] timer_b_val_o,
	output logic load_a_o,
	output logic load_b_o,
	output logic en_a_o,
	output logic en_b_o,
	output logic clr_a_o,
	output logic clr_b_o,
	output logic [1:0] mode_o,
	output logic mode_ch3_o
);
	import opn_reg_pkg::*;

	localparam int A_LO_W = TIMER_A_W - BUS_W; // Bits held in 0x25.

	logic [A_LO_W-1:0] a_lo_data;

	assign a_lo_data = reg_data_i[A_LO_W-1:0];

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			timer_a_val_o <= '0;
			timer_b_val_o <= '0;
			load_a_o <= 1'b0;
			load_b_o <= 1'b0;
			en_a_o <= 1'b0;
			en_b_o <= 1'b0;
			clr_a_o <= 1'b0;
			clr_b_o <= 1'b0;
			mode_o <= MODE_NORMAL;
		end else begin
			clr_a_o <= 1'b0;
			clr_b_o <= 1'b0;
			if (reg_wr_i) begin
				case (reg_index_i)
					REG_TIMER_A_HI[3:0]: begin
						timer_a_val_o[TIMER_A_W-1 -: BUS_W] <= reg_data_i;
					end
					REG_TIMER_A_LO[3:0]: begin
						timer_a_val_o[A_LO_W-1:0] <= a_lo_data;
					end
					REG_TIMER_B[3:0]: begin
						timer_b_val_o <= reg_data_i;
					end
					REG_TIMER_CTRL[3:0]: begin
						mode_o <= reg_data_i.ctrl.mode;
						load_a_o <= reg_data_i.ctrl.load_a;
						load_b_o <= reg_data_i.ctrl.load_b;
						en_a_o <= reg_data_i.ctrl.en_a;
						en_b_o <= reg_data_i.ctrl.en_b;
						clr_a_o <= reg_data_i.ctrl.reset_a; // Not stored.
						clr_b_o <= reg_data_i.ctrl.reset_b;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Special and CSM both split channel 3.
	assign mode_ch3_o = (mode_o != MODE_NORMAL);

endmodule

//--- src/opn_timer.sv
module opn_timer #(
	parameter int CNT_W = 8,
	parameter int PRESCALE = 1
) (
	input logic mclk_i,
	input logic rst_i,
	input logic tick_i,
	input logic run_i,
	input logic flag_en_i,
	input logic clr_i,
	input logic [CNT_W-1:0] load_val_i,
	output logic ovf_o,
	output logic status_o
);

	localparam int PS_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

	logic [PS_W-1:0] ps_q;
	logic [CNT_W-1:0] cnt_q;
	logic step;
	logic wrap;

	assign step = tick_i && (ps_q == PS_W'(PRESCALE - 1)); // Counter advance.
	assign wrap = step && (&cnt_q);

	// ##############################
	// Prescaler
	// ##############################

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			ps_q <= '0;
		end else if (!run_i) begin
			ps_q <= '0;
		end else if (tick_i) begin
			ps_q <= step ? '0 : ps_q + 1'b1;
		end
	end

	// ##############################
	// Counter and flag
	// ##############################

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			cnt_q <= '0;
		end else if (!run_i || wrap) begin
			cnt_q <= load_val_i; // Hold while stopped, reload on overflow.
		end else if (step) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			ovf_o <= 1'b0;
		end else begin
			ovf_o <= run_i && wrap;
		end
	end

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			status_o <= 1'b0;
		end else if (clr_i) begin
			status_o <= 1'b0; // Clear wins over a same cycle set.
		end else if (ovf_o && flag_en_i) begin
			status_o <= 1'b1;
		end
	end

endmodule

//--- src/opn_key_ctrl.sv
module opn_key_ctrl (
	input logic mclk_i,
	input logic rst_i,
	input logic reg_wr_i,
	input logic [3:0] reg_index_i,
	input opn_reg_pkg::opn_bus_word_t reg_data_i,
	input logic [1:0] mode_i,
	input logic ovf_i,
	output logic [opn_reg_pkg::KEY_W-1:0] key_on_o,
	output logic csm_key_o
);
	import opn_reg_pkg::*;

	logic [2:0] ch_code;
	logic [2:0] ch_row;
	logic ch_ok;
	logic key_wr;

	assign ch_code = reg_data_i[2:0];
	assign key_wr = reg_wr_i && (reg_index_i == REG_KEY_ON[3:0]);

	// Codes 0-2 and 4-6 name the six channels. Codes 3 and 7 are holes.
	always_comb begin
		ch_row = 3'(ch_code[1:0]);
		if (ch_code[2]) begin
			ch_row = 3'(ch_code[1:0]) + 3'd3;
		end
		ch_ok = (ch_code[1:0] != 2'b11);
	end

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			key_on_o <= '0;
		end else if (key_wr && ch_ok) begin
			key_on_o[NUM_SLOTS*ch_row +: NUM_SLOTS] <= reg_data_i[BUS_W-1 -: NUM_SLOTS];
		end
	end

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			csm_key_o <= 1'b0;
		end else begin
			csm_key_o <= ovf_i && (mode_i == MODE_CSM); // Timer A drives ch3 key-on.
		end
	end

endmodule

//--- src/opn_reg_ctrl.sv
module opn_reg_ctrl #(
	parameter int TIMER_B_PRESCALE = opn_reg_pkg::TIMER_B_PRESCALE
) (
	input logic mclk_i,
	input logic rst_i,
	input logic addr_wr_i,
	input logic data_wr_i,
	input logic bank_i,
	input logic [opn_reg_pkg::BUS_W-1:0] bus_data_i,
	input logic tick_i,
	output logic timer_a_status_o,
	output logic timer_b_status_o,
	output logic mode_ch3_o,
	output logic csm_key_o,
	output logic [opn_reg_pkg::KEY_W-1:0] key_on_o
);
	import opn_reg_pkg::*;

	logic reg_wr;
	logic [3:0] reg_index;
	opn_bus_word_t reg_data;
	logic [TIMER_A_W-1:0] timer_a_val;
	logic [TIMER_B_W-1:0] timer_b_val;
	logic load_a;
	logic load_b;
	logic en_a;
	logic en_b;
	logic clr_a;
	logic clr_b;
	logic [1:0] mode;
	logic ovf_a;

	opn_bus_latch bus_latch (
		.mclk_i(mclk_i),
		.rst_i(rst_i),
		.addr_wr_i(addr_wr_i),
		.data_wr_i(data_wr_i),
		.bank_i(bank_i),
		.bus_data_i(bus_data_i),
		.reg_wr_o(reg_wr),
		.reg_index_o(reg_index),
		.reg_data_o(reg_data)
	);

	opn_global_regs global_regs (
		.mclk_i(mclk_i),
		.rst_i(rst_i),
		.reg_wr_i(reg_wr),
		.reg_index_i(reg_index),
		.reg_data_i(reg_data),
		.timer_a_val_o(timer_a_val),
		.timer_b_val_o(timer_b_val),
		.load_a_o(load_a),
		.load_b_o(load_b),
		.en_a_o(en_a),
		.en_b_o(en_b),
		.clr_a_o(clr_a),
		.clr_b_o(clr_b),
		.mode_o(mode),
		.mode_ch3_o(mode_ch3_o)
	);

	// Timer A counts every tick.
	opn_timer #(.CNT_W(TIMER_A_W), .PRESCALE(1)) timer_a (
		.mclk_i(mclk_i),
		.rst_i(rst_i),
		.tick_i(tick_i),
		.run_i(load_a),
		.flag_en_i(en_a),
		.clr_i(clr_a),
		.load_val_i(timer_a_val),
		.ovf_o(ovf_a),
		.status_o(timer_a_status_o)
	);

	opn_timer #(.CNT_W(TIMER_B_W), .PRESCALE(TIMER_B_PRESCALE)) timer_b (
		.mclk_i(mclk_i),
		.rst_i(rst_i),
		.tick_i(tick_i),
		.run_i(load_b),
		.flag_en_i(en_b),
		.clr_i(clr_b),
		.load_val_i(timer_b_val),
		.ovf_o(),
		.status_o(timer_b_status_o)
	);

	opn_key_ctrl key_ctrl (
		.mclk_i(mclk_i),
		.rst_i(rst_i),
		.reg_wr_i(reg_wr),
		.reg_index_i(reg_index),
		.reg_data_i(reg_data),
		.mode_i(mode),
		.ovf_i(ovf_a),
		.key_on_o(key_on_o),
		.csm_key_o(csm_key_o)
	);

endmodule

//--- tests/opn_reg_ctrl_tb.sv
module opn_reg_ctrl_tb;
	import opn_reg_pkg::*;

	logic mclk;
	logic rst;
	logic addr_wr;
	logic data_wr;
	logic bank;
	logic [BUS_W-1:0] bus_data;
	logic tick;
	logic timer_a_status;
	logic timer_b_status;
	logic mode_ch3;
	logic csm_key;
	logic [KEY_W-1:0] key_on;

	integer seed;
	int errors;
	int checks;
	int pulse_count;
	int total_ticks;
	int limit_cycles;
	int fd;
	byte op_q[$];
	int a_q[$];
	int b_q[$];
	int c_q[$];
	int line_q[$];

	opn_reg_ctrl #(.TIMER_B_PRESCALE(TIMER_B_PRESCALE)) opn_reg_ctrl_i (
		.mclk_i(mclk),
		.rst_i(rst),
		.addr_wr_i(addr_wr),
		.data_wr_i(data_wr),
		.bank_i(bank),
		.bus_data_i(bus_data),
		.tick_i(tick),
		.timer_a_status_o(timer_a_status),
		.timer_b_status_o(timer_b_status),
		.mode_ch3_o(mode_ch3),
		.csm_key_o(csm_key),
		.key_on_o(key_on)
	);

	initial begin
		mclk = 1'b0;
		forever #5 mclk = ~mclk;
	end

	always @(posedge mclk) begin
		if (!rst && csm_key) begin
			pulse_count++; // Each pulse is one cycle wide.
		end
	end

	// ##############################
	// Compare tasks
	// ##############################

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			$display("[ERROR] %s expected %0b actual %0b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_key(input string name, input logic [KEY_W-1:0] exp,
			input logic [KEY_W-1:0] act);
		checks++;
		if (act !== exp) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			$display("[ERROR] %s expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	// ##############################
	// Bus and tick drivers
	// ##############################

	task automatic bus_write(input logic bk, input logic [7:0] addr, input logic [7:0] data);
		@(posedge mclk);
		addr_wr <= 1'b1;
		bank <= bk;
		bus_data <= addr;
		@(posedge mclk);
		addr_wr <= 1'b0;
		data_wr <= 1'b1;
		bus_data <= data;
		@(posedge mclk);
		data_wr <= 1'b0;
		repeat (2) @(posedge mclk); // Register lands two cycles after the data strobe.
	endtask

	task automatic drive_ticks(input int count);
		int gap;
		repeat (count) begin
			@(posedge mclk);
			tick <= 1'b1;
			@(posedge mclk);
			tick <= 1'b0;
			gap = 1 + ($unsigned($random(seed)) % 4);
			repeat (gap - 1) @(posedge mclk);
		end
		repeat (2) @(posedge mclk); // Status and CSM key settle.
	endtask

	task automatic read_stim(input int fh);
		string text;
		string cmd;
		int ln;
		int n;
		int a;
		int b;
		int c;
		ln = 0;
		while (!$feof(fh)) begin
			text = "";
			n = $fgets(text, fh);
			ln++;
			a = 0;
			b = 0;
			c = 0;
			if (n > 0 && text.getc(0) != "#" && $sscanf(text, "%s", cmd) == 1) begin
				if (cmd == "W" || cmd == "K") begin
					n = $sscanf(text, "%s %h %h %h", cmd, a, b, c);
				end else begin
					n = $sscanf(text, "%s %d %d", cmd, a, b);
				end
				op_q.push_back(cmd.getc(0));
				a_q.push_back(a);
				b_q.push_back(b);
				c_q.push_back(c);
				line_q.push_back(ln);
				if (cmd == "T") begin
					total_ticks += a;
				end
			end
		end
	endtask

	task automatic run_cmd(input int i);
		string where;
		where = $sformatf("line %0d", line_q[i]);
		case (op_q[i])
			"W": bus_write(a_q[i] != 0, 8'(b_q[i]), 8'(c_q[i]));
			"T": drive_ticks(a_q[i]);
			"S": begin
				@(negedge mclk);
				check_flag({"status A ", where}, a_q[i] != 0, timer_a_status);
				check_flag({"status B ", where}, b_q[i] != 0, timer_b_status);
			end
			"K": begin
				@(negedge mclk);
				check_key({"key_on ", where}, KEY_W'(a_q[i]), key_on);
			end
			"P": begin
				@(negedge mclk);
				check_count({"CSM pulses ", where}, a_q[i], pulse_count);
				pulse_count = 0;
			end
			"M": begin
				@(negedge mclk);
				check_flag({"mode_ch3 ", where}, a_q[i] != 0, mode_ch3);
			end
			default: begin
				$display("Unknown command in the stimulus file at %s", where);
				errors++;
			end
		endcase
	endtask

	initial begin
		rst = 1'b1;
		addr_wr = 1'b0;
		data_wr = 1'b0;
		bank = 1'b0;
		bus_data = '0;
		tick = 1'b0;
		seed = 35994;
		errors = 0;
		checks = 0;
		pulse_count = 0;
		total_ticks = 0;
		fd = $fopen("tests/opn_reg_ctrl_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file tests/opn_reg_ctrl_stim.txt");
			$display("Testbench failed");
			$finish;
		end else begin
			read_stim(fd);
			$fclose(fd);
			limit_cycles = total_ticks * 6 + 200 * op_q.size();
			fork
				begin
					repeat (limit_cycles) @(posedge mclk);
					$display("Timeout, the run did not finish in %0d cycles", limit_cycles);
					$display("Testbench failed");
					$finish;
				end
			join_none
			repeat (16) @(posedge mclk);
			rst <= 1'b0;
			foreach (op_q[i]) begin
				run_cmd(i);
			end
			$display("Checks: %0d, errors: %0d", checks, errors);
			if (errors == 0) begin
				$display("Testbench passed");
			end else begin
				$display("Testbench failed");
			end
			$finish;
		end
	end

endmodule

//--- tests/opn_reg_ctrl_stim.txt
# Commands: W bank addr data (hex), T ticks, S status_a status_b,
# K key_on (hex), P csm_pulses since last P, M mode_ch3.
S 0 0
K 000000
M 0
# Timer A loaded with 1020, flag enabled.
W 0 24 FF
W 0 25 00
W 0 27 05
T 3
S 0 0
T 1
S 1 0
W 0 27 15
S 0 0
# Timer B loaded with 254, timer A flag disabled.
W 0 26 FE
W 0 27 0B
T 31
S 0 0
T 1
S 0 1
W 0 27 20
S 0 0
# Key-on table.
W 0 28 F0
W 0 28 55
W 0 28 A6
K A5000F
W 0 28 F3
W 0 28 F7
K A5000F
# CSM mode with timer A period 4.
W 0 27 81
T 12
P 3
M 1
W 0 27 01
M 0
T 8
P 0
W 0 27 00
# Writes outside the global range are dropped.
W 1 24 00
W 0 30 00
W 0 27 05
T 3
S 0 0
T 1
S 1 0

//--- opn_reg_ctrl.f
src/opn_reg_pkg.sv
src/opn_bus_latch.sv
src/opn_global_regs.sv
src/opn_timer.sv
src/opn_key_ctrl.sv
src/opn_reg_ctrl.sv
tests/opn_reg_ctrl_tb.sv
